/* avr_params.svh */
// Shared widths for the AVR-style core
// Opcode, address, data byte and register file geometry

`ifndef AVR_PARAMS_SVH
`define AVR_PARAMS_SVH

// One program word per fetch
`define AVR_INSN_W 16

// Program and data space share one address width
`define AVR_ADDR_W 16

// Registers and data memory are byte wide
`define AVR_DATA_W 8

`define AVR_NUM_REGS 32
`define AVR_REG_SEL_W 5

`endif

/* avr_pkg.sv */
// Types shared by the AVR-style core
// ALU operations, opcode field views and status bit positions

package avr_pkg;

	// ALU function select, MOVE passes Rr through
	typedef enum logic [3:0] {
		ALU_MOVE,
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_EOR,
		ALU_LSR,
		ALU_ROR,
		ALU_ASR
	} alu_op_t;

	// Two-register form, Rd 0-31 and Rr 0-31
	typedef struct packed {
		logic [5:0] major;
		logic       r_hi;
		logic [4:0] d;
		logic [3:0] r_lo;
	} reg_form_t;

	// Immediate form, Rd is 16 + d_lo
	typedef struct packed {
		logic [3:0] major;
		logic [3:0] k_hi;
		logic [3:0] d_lo;
		logic [3:0] k_lo;
	} imm_form_t;

	typedef union packed {
		reg_form_t reg_form;
		imm_form_t imm_form;
	} opcode_t;

	// Position inside a multi-cycle instruction
	typedef logic [1:0] step_t;

	// Status register bits
	localparam int SREG_C = 0;
	localparam int SREG_Z = 1;
	localparam int SREG_N = 2;
	localparam int SREG_V = 3;
	localparam int SREG_S = 4;
	localparam int SREG_H = 5;

endpackage

/* avr_alu.sv */
// Combinational ALU for the AVR-style core
// Byte arithmetic, logic and shifts with AVR status flags, word move
`timescale 1ns/1ps
`include "avr_params.svh"

module avr_alu (
	input  avr_pkg::alu_op_t            op,
	input  logic                        carry_in_en,
	input  logic                        word,
	input  logic [2*`AVR_DATA_W-1:0]    rd,
	input  logic [`AVR_DATA_W-1:0]      rr,
	input  logic [`AVR_DATA_W-1:0]      sreg_in,
	output logic [2*`AVR_DATA_W-1:0]    result,
	output logic [`AVR_DATA_W-1:0]      sreg_out
);
	import avr_pkg::*;

	localparam int DW = `AVR_DATA_W;

	logic [DW-1:0] a;
	logic [DW-1:0] b;
	logic [DW-1:0] r;
	logic cin;
	logic [DW:0] sum;
	logic [DW:0] diff;
	logic flag_c;
	logic flag_z;
	logic flag_n;
	logic flag_v;
	logic flag_h;

	assign a = rd[DW-1:0];
	assign b = rr;
	// Carry only feeds ADC, SBC, CPC, SBCI and ROR
	assign cin = carry_in_en & sreg_in[SREG_C];
	assign sum = {1'b0, a} + {1'b0, b} + {{DW{1'b0}}, cin};
	assign diff = {1'b0, a} - {1'b0, b} - {{DW{1'b0}}, cin};

	always_comb begin
		r = b;
		flag_c = sreg_in[SREG_C];
		flag_h = sreg_in[SREG_H];
		flag_v = 1'b0;
		case (op)
			ALU_ADD: begin
				r = sum[DW-1:0];
				flag_c = sum[DW];
				// Carry out of bit 3
				flag_h = (a[3] & b[3]) | (b[3] & ~r[3]) | (~r[3] & a[3]);
				flag_v = (a[DW-1] & b[DW-1] & ~r[DW-1])
					| (~a[DW-1] & ~b[DW-1] & r[DW-1]);
			end
			ALU_SUB: begin
				r = diff[DW-1:0];
				flag_c = diff[DW];
				// Borrow from bit 4
				flag_h = (~a[3] & b[3]) | (b[3] & r[3]) | (r[3] & ~a[3]);
				flag_v = (a[DW-1] & ~b[DW-1] & ~r[DW-1])
					| (~a[DW-1] & b[DW-1] & r[DW-1]);
			end
			ALU_AND: r = a & b;
			ALU_OR:  r = a | b;
			ALU_EOR: r = a ^ b;
			ALU_LSR: begin
				r = {1'b0, a[DW-1:1]};
				flag_c = a[0];
			end
			ALU_ROR: begin
				r = {cin, a[DW-1:1]};
				flag_c = a[0];
			end
			ALU_ASR: begin
				r = {a[DW-1], a[DW-1:1]};
				flag_c = a[0];
			end
			default: r = b;
		endcase

		flag_n = r[DW-1];
		flag_z = (r == '0);
		// SBC, SBCI and CPC only clear Z, never set it
		if (op == ALU_SUB && carry_in_en)
			flag_z = flag_z & sreg_in[SREG_Z];
		// Shift overflow is N xor the bit shifted out
		if (op == ALU_LSR || op == ALU_ROR || op == ALU_ASR)
			flag_v = flag_n ^ flag_c;

		sreg_out = sreg_in;
		if (op != ALU_MOVE) begin
			sreg_out[SREG_C] = flag_c;
			sreg_out[SREG_Z] = flag_z;
			sreg_out[SREG_N] = flag_n;
			sreg_out[SREG_V] = flag_v;
			sreg_out[SREG_S] = flag_n ^ flag_v;
			sreg_out[SREG_H] = flag_h;
		end

		// MOVW carries the whole pair
		if (word && op == ALU_MOVE)
			result = rd;
		else
			result = {{DW{1'b0}}, r};
	end

endmodule

/* avr_regfile.sv */
// 32 x 8-bit register file for the AVR-style core
// Registered byte and word reads with write-through, byte or pair writes
`timescale 1ns/1ps
`include "avr_params.svh"

module avr_regfile (
	input  logic                        clk,
	input  logic                        reset,
	input  logic [`AVR_REG_SEL_W-1:0]   sel_a,
	input  logic [`AVR_REG_SEL_W-1:0]   sel_b,
	input  logic                        wr_en,
	input  logic                        wr_word,
	input  logic [`AVR_REG_SEL_W-1:0]   wr_sel,
	input  logic [2*`AVR_DATA_W-1:0]    wr_data,
	output logic [2*`AVR_DATA_W-1:0]    ra,
	output logic [`AVR_DATA_W-1:0]      rb
);
	localparam int DW = `AVR_DATA_W;

	logic [DW-1:0] regs [`AVR_NUM_REGS];
	logic [`AVR_REG_SEL_W-1:0] sel_a_hi;
	logic [`AVR_REG_SEL_W-1:0] wr_sel_hi;

	assign sel_a_hi = sel_a + 1'b1;
	assign wr_sel_hi = wr_sel + 1'b1;

	// Array contents, or the byte being written on this edge
	function automatic logic [DW-1:0] read_byte(
		input logic [`AVR_REG_SEL_W-1:0] idx
	);
		logic [DW-1:0] value;
		value = regs[idx];
		if (wr_en && wr_word && idx == wr_sel_hi)
			value = wr_data[2*DW-1:DW];
		if (wr_en && idx == wr_sel)
			value = wr_data[DW-1:0];
		return value;
	endfunction

	always_ff @(posedge clk) begin
		if (wr_en) begin
			regs[wr_sel] <= wr_data[DW-1:0];
			// Pair writes also fill the odd register
			if (wr_word)
				regs[wr_sel_hi] <= wr_data[2*DW-1:DW];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ra <= '0;
			rb <= '0;
		end else begin
			ra <= {read_byte(sel_a_hi), read_byte(sel_a)};
			rb <= read_byte(sel_b);
		end
	end

endmodule

/* avr_decode.sv */
// First pipeline stage of the AVR-style core
// Owns the PC, decodes the opcode into register selects and ALU controls,
// and sequences LDS/STS on the data memory
`timescale 1ns/1ps
`include "avr_params.svh"

module avr_decode (
	input  logic                        clk,
	input  logic                        reset,
	input  logic [`AVR_INSN_W-1:0]      cdata,
	input  logic [2*`AVR_DATA_W-1:0]    ra,
	input  logic [`AVR_DATA_W-1:0]      data_read,
	output logic [`AVR_ADDR_W-1:0]      pc,
	output logic [`AVR_ADDR_W-1:0]      data_addr,
	output logic                        data_wen,
	output logic                        data_ren,
	output logic [`AVR_DATA_W-1:0]      data_write,
	output logic [`AVR_REG_SEL_W-1:0]   sel_a,
	output logic [`AVR_REG_SEL_W-1:0]   sel_b,
	output avr_pkg::alu_op_t            alu_op,
	output logic                        use_carry,
	output logic                        use_const,
	output logic [`AVR_DATA_W-1:0]      const_value,
	output logic                        store,
	output logic                        word,
	output logic [`AVR_REG_SEL_W-1:0]   dest
);
	import avr_pkg::*;

	// Address of the word now on cdata
	logic [`AVR_ADDR_W-1:0] reg_pc;
	// Low for the first cycle out of reset, cdata is not yet a real fetch
	logic fetch_valid;
	step_t step;
	step_t next_step;
	logic [`AVR_INSN_W-1:0] prev_opcode;
	opcode_t op;
	logic advance;
	logic [`AVR_REG_SEL_W-1:0] rd_sel;
	logic [`AVR_REG_SEL_W-1:0] rr_sel;
	logic [`AVR_REG_SEL_W-1:0] rdi_sel;
	logic [`AVR_DATA_W-1:0] k_imm;

	// Later steps reuse the opcode latched at step 0
	always_comb begin
		if (!fetch_valid)
			op = '0;
		else if (step == 2'd0)
			op = cdata;
		else
			op = prev_opcode;
	end

	// Field views of the same word
	assign rd_sel = op.reg_form.d;
	assign rr_sel = {op.reg_form.r_hi, op.reg_form.r_lo};
	assign rdi_sel = {1'b1, op.imm_form.d_lo};
	assign k_imm = {op.imm_form.k_hi, op.imm_form.k_lo};

	// Next fetch address
	assign pc = advance ? reg_pc + 1'b1 : reg_pc;

	always_ff @(posedge clk) begin
		if (reset) begin
			reg_pc <= '0;
			step <= '0;
			fetch_valid <= 1'b0;
		end else begin
			reg_pc <= pc;
			step <= next_step;
			fetch_valid <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		prev_opcode <= op;
	end

	always_comb begin
		// Single cycle, no memory traffic, no write-back
		advance = fetch_valid && (step == 2'd0);
		next_step = 2'd0;
		data_addr = '0;
		data_wen = 1'b0;
		data_ren = 1'b0;
		data_write = '0;
		alu_op = ALU_MOVE;
		use_carry = 1'b0;
		use_const = 1'b0;
		const_value = '0;
		store = 1'b0;
		word = 1'b0;
		sel_a = rd_sel;
		sel_b = rr_sel;
		dest = rd_sel;

		casez (op.reg_form.major)
			6'b000000: begin
				// MOVW, both register numbers are pair indices
				if (!op.reg_form.r_hi && op.reg_form.d[4]) begin
					sel_a = {op.imm_form.k_lo, 1'b0};
					dest = {op.imm_form.d_lo, 1'b0};
					word = 1'b1;
					store = 1'b1;
				end
			end
			// CPC and CP only touch flags
			6'b000001: begin
				alu_op = ALU_SUB;
				use_carry = 1'b1;
			end
			6'b000101: alu_op = ALU_SUB;
			6'b000010: begin
				alu_op = ALU_SUB;
				use_carry = 1'b1;
				store = 1'b1;
			end
			6'b000110: begin
				alu_op = ALU_SUB;
				store = 1'b1;
			end
			// ADD and ADC, LSL and ROL when Rd equals Rr
			6'b000011: begin
				alu_op = ALU_ADD;
				store = 1'b1;
			end
			6'b000111: begin
				alu_op = ALU_ADD;
				use_carry = 1'b1;
				store = 1'b1;
			end
			6'b001000: begin
				alu_op = ALU_AND;
				store = 1'b1;
			end
			6'b001001: begin
				alu_op = ALU_EOR;
				store = 1'b1;
			end
			6'b001010: begin
				alu_op = ALU_OR;
				store = 1'b1;
			end
			6'b001011: store = 1'b1;
			// Immediate group on the upper sixteen registers
			6'b0011??, 6'b0100??, 6'b0101??, 6'b0110??, 6'b0111??, 6'b1110??: begin
				sel_a = rdi_sel;
				dest = rdi_sel;
				use_const = 1'b1;
				const_value = k_imm;
				store = (op.imm_form.major != 4'b0011);
				case (op.imm_form.major)
					4'b0011, 4'b0101: alu_op = ALU_SUB;
					4'b0100: begin
						alu_op = ALU_SUB;
						use_carry = 1'b1;
					end
					4'b0110: alu_op = ALU_OR;
					4'b0111: alu_op = ALU_AND;
					default: alu_op = ALU_MOVE;
				endcase
			end
			6'b100100: begin
				// LDS when r_hi is low, STS when high
				if (op.reg_form.r_lo == 4'b0000) begin
					case (step)
						2'd0: next_step = 2'd1;
						2'd1: begin
							// cdata is now the address word
							data_addr = cdata;
							if (op.reg_form.r_hi) begin
								data_wen = 1'b1;
								data_write = ra[`AVR_DATA_W-1:0];
								advance = 1'b1;
							end else begin
								data_ren = 1'b1;
								next_step = 2'd2;
							end
						end
						default: begin
							// Load data lands in Rd as a constant
							advance = 1'b1;
							use_const = 1'b1;
							const_value = data_read;
							store = 1'b1;
						end
					endcase
				end
			end
			6'b100101: begin
				// One-operand group
				if (!op.reg_form.r_hi) begin
					case (op.reg_form.r_lo)
						4'b0000: begin
							alu_op = ALU_EOR;
							use_const = 1'b1;
							const_value = 8'hff;
							store = 1'b1;
						end
						4'b0011: begin
							alu_op = ALU_ADD;
							use_const = 1'b1;
							const_value = 8'h01;
							store = 1'b1;
						end
						4'b1010: begin
							alu_op = ALU_SUB;
							use_const = 1'b1;
							const_value = 8'h01;
							store = 1'b1;
						end
						4'b0101: begin
							alu_op = ALU_ASR;
							store = 1'b1;
						end
						4'b0110: begin
							alu_op = ALU_LSR;
							store = 1'b1;
						end
						4'b0111: begin
							// Old carry rotates into bit 7
							alu_op = ALU_ROR;
							use_carry = 1'b1;
							store = 1'b1;
						end
						default: store = 1'b0;
					endcase
				end
			end
			default: store = 1'b0;
		endcase
	end

endmodule

/* avr_execute.sv */
// Second pipeline stage of the AVR-style core
// Latches decode controls, picks Rr or a constant, runs the ALU,
// keeps the status register and drives register write-back
`timescale 1ns/1ps
`include "avr_params.svh"

module avr_execute (
	input  logic                        clk,
	input  logic                        reset,
	input  avr_pkg::alu_op_t            alu_op,
	input  logic                        use_carry,
	input  logic                        use_const,
	input  logic [`AVR_DATA_W-1:0]      const_value,
	input  logic                        store,
	input  logic                        word,
	input  logic [`AVR_REG_SEL_W-1:0]   dest,
	input  logic [2*`AVR_DATA_W-1:0]    ra,
	input  logic [`AVR_DATA_W-1:0]      rb,
	output logic                        wr_en,
	output logic                        wr_word,
	output logic [`AVR_REG_SEL_W-1:0]   wr_sel,
	output logic [2*`AVR_DATA_W-1:0]    wr_data
);
	import avr_pkg::*;

	alu_op_t alu_op_q;
	logic use_carry_q;
	logic use_const_q;
	logic [`AVR_DATA_W-1:0] const_value_q;
	logic store_q;
	logic word_q;
	logic [`AVR_REG_SEL_W-1:0] dest_q;
	logic [`AVR_DATA_W-1:0] sreg;
	logic [`AVR_DATA_W-1:0] sreg_next;
	logic [`AVR_DATA_W-1:0] rr;

	// Controls line up with the register read data
	always_ff @(posedge clk) begin
		if (reset) begin
			alu_op_q <= ALU_MOVE;
			store_q <= 1'b0;
			sreg <= '0;
		end else begin
			alu_op_q <= alu_op;
			store_q <= store;
			sreg <= sreg_next;
		end
	end

	always_ff @(posedge clk) begin
		use_carry_q <= use_carry;
		use_const_q <= use_const;
		const_value_q <= const_value;
		word_q <= word;
		dest_q <= dest;
	end

	// Immediates and load data replace Rr
	assign rr = use_const_q ? const_value_q : rb;

	avr_alu u_alu (
		.op          (alu_op_q),
		.carry_in_en (use_carry_q),
		.word        (word_q),
		.rd          (ra),
		.rr          (rr),
		.sreg_in     (sreg),
		.result      (wr_data),
		.sreg_out    (sreg_next)
	);

	assign wr_en = store_q;
	assign wr_word = word_q;
	assign wr_sel = dest_q;

endmodule

/* avr_cpu.sv */
// Top level of the two-stage AVR-style core
// Connects decode, register file and execute
`timescale 1ns/1ps
`include "avr_params.svh"

module avr_cpu (
	input  logic                        clk,
	input  logic                        reset,
	output logic [`AVR_ADDR_W-1:0]      pc,
	input  logic [`AVR_INSN_W-1:0]      cdata,
	output logic [`AVR_ADDR_W-1:0]      data_addr,
	output logic                        data_wen,
	output logic                        data_ren,
	input  logic [`AVR_DATA_W-1:0]      data_read,
	output logic [`AVR_DATA_W-1:0]      data_write
);
	import avr_pkg::*;

	// Decode to register file
	logic [`AVR_REG_SEL_W-1:0] sel_a;
	logic [`AVR_REG_SEL_W-1:0] sel_b;
	logic [2*`AVR_DATA_W-1:0] ra;
	logic [`AVR_DATA_W-1:0] rb;

	// Decode to execute
	alu_op_t alu_op;
	logic use_carry;
	logic use_const;
	logic [`AVR_DATA_W-1:0] const_value;
	logic store;
	logic word;
	logic [`AVR_REG_SEL_W-1:0] dest;

	// Write-back
	logic wr_en;
	logic wr_word;
	logic [`AVR_REG_SEL_W-1:0] wr_sel;
	logic [2*`AVR_DATA_W-1:0] wr_data;

	avr_decode u_decode (
		.clk         (clk),
		.reset       (reset),
		.cdata       (cdata),
		.ra          (ra),
		.data_read   (data_read),
		.pc          (pc),
		.data_addr   (data_addr),
		.data_wen    (data_wen),
		.data_ren    (data_ren),
		.data_write  (data_write),
		.sel_a       (sel_a),
		.sel_b       (sel_b),
		.alu_op      (alu_op),
		.use_carry   (use_carry),
		.use_const   (use_const),
		.const_value (const_value),
		.store       (store),
		.word        (word),
		.dest        (dest)
	);

	avr_regfile u_regfile (
		.clk     (clk),
		.reset   (reset),
		.sel_a   (sel_a),
		.sel_b   (sel_b),
		.wr_en   (wr_en),
		.wr_word (wr_word),
		.wr_sel  (wr_sel),
		.wr_data (wr_data),
		.ra      (ra),
		.rb      (rb)
	);

	avr_execute u_execute (
		.clk         (clk),
		.reset       (reset),
		.alu_op      (alu_op),
		.use_carry   (use_carry),
		.use_const   (use_const),
		.const_value (const_value),
		.store       (store),
		.word        (word),
		.dest        (dest),
		.ra          (ra),
		.rb          (rb),
		.wr_en       (wr_en),
		.wr_word     (wr_word),
		.wr_sel      (wr_sel),
		.wr_data     (wr_data)
	);

endmodule

/* tb_avr_cpu.sv */
// Testbench for the two-stage AVR-style core
// Builds random programs, runs them against memory models and a reference model
`timescale 1ns/1ps
`include "avr_params.svh"

module tb_avr_cpu;

	localparam int BODY_LEN = 24;
	localparam int STORE_TIMEOUT = 500;
	localparam logic [`AVR_ADDR_W-1:0] DUMP_BASE = 16'hf000;

	// Two-register opcode majors
	localparam logic [5:0] M_CPC = 6'b000001;
	localparam logic [5:0] M_SBC = 6'b000010;
	localparam logic [5:0] M_ADD = 6'b000011;
	localparam logic [5:0] M_CP  = 6'b000101;
	localparam logic [5:0] M_SUB = 6'b000110;
	localparam logic [5:0] M_ADC = 6'b000111;
	localparam logic [5:0] M_AND = 6'b001000;
	localparam logic [5:0] M_EOR = 6'b001001;
	localparam logic [5:0] M_OR  = 6'b001010;
	localparam logic [5:0] M_MOV = 6'b001011;

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic [`AVR_INSN_W-1:0] cdata = '0;
	logic [`AVR_DATA_W-1:0] data_read = '0;
	logic [`AVR_ADDR_W-1:0] pc;
	logic [`AVR_ADDR_W-1:0] data_addr;
	logic data_wen;
	logic data_ren;
	logic [`AVR_DATA_W-1:0] data_write;

	// Program and data memory models
	logic [`AVR_INSN_W-1:0] pmem [1024];
	logic [`AVR_DATA_W-1:0] dmem [65536];
	logic [9:0] wr_ptr;

	// Reference model state, only C reaches a visible result
	logic [`AVR_DATA_W-1:0] m_regs [32];
	logic m_c;

	logic [`AVR_ADDR_W-1:0] exp_addr [$];
	logic [`AVR_DATA_W-1:0] exp_data [$];
	logic [`AVR_ADDR_W-1:0] got_addr [$];
	logic [`AVR_DATA_W-1:0] got_data [$];

	integer seed;
	int errors;
	int checks;
	logic timed_out;

	avr_cpu DUT (
		.clk        (clk),
		.reset      (reset),
		.pc         (pc),
		.cdata      (cdata),
		.data_addr  (data_addr),
		.data_wen   (data_wen),
		.data_ren   (data_ren),
		.data_read  (data_read),
		.data_write (data_write)
	);

	always #2 clk = ~clk;

	// One-cycle program fetch, one-cycle data read, stores logged
	always @(posedge clk) begin
		cdata <= pmem[pc[9:0]];
		if (data_ren)
			data_read <= dmem[data_addr];
		if (data_wen) begin
			dmem[data_addr] <= data_write;
			got_addr.push_back(data_addr);
			got_data.push_back(data_write);
		end
	end

	function automatic int rand_below(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	function automatic logic [5:0] reg_major(input int i);
		case (i)
			0: return M_ADD;
			1: return M_ADC;
			2: return M_SUB;
			3: return M_SBC;
			4: return M_CP;
			5: return M_CPC;
			6: return M_AND;
			7: return M_EOR;
			8: return M_OR;
			default: return M_MOV;
		endcase
	endfunction

	// CPI, SBCI, SUBI, ORI, ANDI, LDI
	function automatic logic [3:0] imm_major(input int i);
		case (i)
			0: return 4'h3;
			1: return 4'h4;
			2: return 4'h5;
			3: return 4'h6;
			4: return 4'h7;
			default: return 4'he;
		endcase
	endfunction

	// COM, INC, DEC, ASR, LSR, ROR
	function automatic logic [3:0] unary_code(input int i);
		case (i)
			0: return 4'h0;
			1: return 4'h3;
			2: return 4'ha;
			3: return 4'h5;
			4: return 4'h6;
			default: return 4'h7;
		endcase
	endfunction

	task automatic check_byte(input string name, input logic [`AVR_DATA_W-1:0] expected,
		input logic [`AVR_DATA_W-1:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("[ERROR] %s: expected %h, got %h", name, expected, actual);
		end
	endtask

	task automatic check_addr(input string name, input logic [`AVR_ADDR_W-1:0] expected,
		input logic [`AVR_ADDR_W-1:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("[ERROR] %s: expected %h, got %h", name, expected, actual);
		end
	endtask

	task automatic put_word(input logic [`AVR_INSN_W-1:0] w);
		pmem[wr_ptr] = w;
		wr_ptr = wr_ptr + 10'd1;
	endtask

	// Add or subtract with optional carry in
	task automatic arith_model(input logic [4:0] d, input logic [7:0] b, input logic sub,
		input logic carry, input logic keep);
		logic cin;
		logic [8:0] full;
		cin = carry & m_c;
		if (sub)
			full = {1'b0, m_regs[d]} - {1'b0, b} - {8'b0, cin};
		else
			full = {1'b0, m_regs[d]} + {1'b0, b} + {8'b0, cin};
		m_c = full[8];
		if (keep)
			m_regs[d] = full[7:0];
	endtask

	// Logic ops leave C alone
	task automatic bitwise_model(input logic [4:0] d, input logic [7:0] r);
		m_regs[d] = r;
	endtask

	task automatic shift_model(input logic [4:0] d, input logic [3:0] code);
		logic [7:0] a;
		logic [7:0] r;
		a = m_regs[d];
		case (code)
			4'h6: r = {1'b0, a[7:1]};
			4'h7: r = {m_c, a[7:1]};
			default: r = {a[7], a[7:1]};
		endcase
		m_c = a[0];
		m_regs[d] = r;
	endtask

	task automatic reg_insn(input logic [5:0] major, input logic [4:0] d, input logic [4:0] r);
		logic [7:0] b;
		b = m_regs[r];
		put_word({major, r[4], d, r[3:0]});
		case (major)
			M_ADD: arith_model(d, b, 1'b0, 1'b0, 1'b1);
			M_ADC: arith_model(d, b, 1'b0, 1'b1, 1'b1);
			M_SUB: arith_model(d, b, 1'b1, 1'b0, 1'b1);
			M_SBC: arith_model(d, b, 1'b1, 1'b1, 1'b1);
			M_CP:  arith_model(d, b, 1'b1, 1'b0, 1'b0);
			M_CPC: arith_model(d, b, 1'b1, 1'b1, 1'b0);
			M_AND: bitwise_model(d, m_regs[d] & b);
			M_EOR: bitwise_model(d, m_regs[d] ^ b);
			M_OR:  bitwise_model(d, m_regs[d] | b);
			default: m_regs[d] = b;
		endcase
	endtask

	// Immediate forms only reach r16 to r31
	task automatic imm_insn(input logic [3:0] major, input logic [3:0] d_lo, input logic [7:0] k);
		logic [4:0] d;
		d = {1'b1, d_lo};
		put_word({major, k[7:4], d_lo, k[3:0]});
		case (major)
			4'h3: arith_model(d, k, 1'b1, 1'b0, 1'b0);
			4'h4: arith_model(d, k, 1'b1, 1'b1, 1'b1);
			4'h5: arith_model(d, k, 1'b1, 1'b0, 1'b1);
			4'h6: bitwise_model(d, m_regs[d] | k);
			4'h7: bitwise_model(d, m_regs[d] & k);
			default: m_regs[d] = k;
		endcase
	endtask

	task automatic unary_insn(input logic [3:0] code, input logic [4:0] d);
		put_word({7'b1001010, d, code});
		case (code)
			4'h0: bitwise_model(d, ~m_regs[d]);
			4'h3: arith_model(d, 8'h01, 1'b0, 1'b0, 1'b1);
			4'ha: arith_model(d, 8'h01, 1'b1, 1'b0, 1'b1);
			default: shift_model(d, code);
		endcase
	endtask

	task automatic movw_insn(input logic [4:0] d, input logic [4:0] r);
		logic [7:0] lo;
		logic [7:0] hi;
		lo = m_regs[r];
		hi = m_regs[r + 5'd1];
		put_word({8'h01, d[4:1], r[4:1]});
		m_regs[d] = lo;
		m_regs[d + 5'd1] = hi;
	endtask

	task automatic lds_insn(input logic [4:0] d, input logic [`AVR_ADDR_W-1:0] addr);
		put_word({7'b1001000, d, 4'h0});
		put_word(addr);
		m_regs[d] = dmem[addr];
	endtask

	task automatic sts_insn(input logic [4:0] d, input logic [`AVR_ADDR_W-1:0] addr);
		put_word({7'b1001001, d, 4'h0});
		put_word(addr);
		exp_addr.push_back(addr);
		exp_data.push_back(m_regs[d]);
	endtask

	task automatic build_program(input int kind);
		logic [4:0] d;
		logic [4:0] r;
		logic [4:0] last;
		int sel;
		wr_ptr = '0;
		m_c = 1'b0;
		for (int i = 0; i < 1024; i++)
			pmem[10'(i)] = '0;
		exp_addr.delete();
		exp_data.delete();
		// Two NOPs, then every register gets a known value
		put_word(16'h0000);
		put_word(16'h0000);
		for (int i = 0; i < 16; i++)
			imm_insn(4'he, 4'(i), 8'($random(seed)));
		for (int i = 0; i < 16; i++)
			reg_insn(M_MOV, 5'(i), 5'(16 + rand_below(16)));
		last = 5'd31;
		case (kind)
			1: begin
				// Half the ops reuse the last result as Rd
				for (int i = 0; i < BODY_LEN; i++) begin
					d = (rand_below(2) != 0) ? last : 5'(rand_below(32));
					r = (rand_below(3) == 0) ? last : 5'(rand_below(32));
					sel = rand_below(16);
					if (sel < 10)
						reg_insn(reg_major(sel), d, r);
					else
						imm_insn(imm_major(sel - 10), d[3:0], 8'($random(seed)));
					last = (sel < 10) ? d : {1'b1, d[3:0]};
				end
			end
			2: begin
				// 16-bit add, subtract and compare chains on register pairs
				for (int i = 0; i < BODY_LEN / 2; i++) begin
					d = 5'(2 * rand_below(16));
					r = 5'(2 * rand_below(16));
					sel = rand_below(3);
					if (sel == 0) begin
						reg_insn(M_ADD, d, r);
						reg_insn(M_ADC, d + 5'd1, r + 5'd1);
					end else if (sel == 1) begin
						reg_insn(M_SUB, d, r);
						reg_insn(M_SBC, d + 5'd1, r + 5'd1);
					end else begin
						reg_insn(M_CP, d, r);
						reg_insn(M_CPC, d + 5'd1, r + 5'd1);
						// Compare carry made visible
						reg_insn(M_ADC, d, r);
					end
				end
			end
			3: begin
				for (int i = 0; i < 8; i++)
					lds_insn(5'(rand_below(32)), 16'($random(seed)) & 16'h7fff);
				for (int i = 0; i < 4; i++)
					movw_insn(5'(2 * rand_below(16)), 5'(2 * rand_below(16)));
				for (int i = 0; i < 12; i++)
					unary_insn(unary_code(rand_below(6)), 5'(rand_below(32)));
			end
			default: ;
		endcase
		// Register dump, own area per program
		for (int i = 0; i < 32; i++)
			sts_insn(5'(i), DUMP_BASE + 16'(kind * 32 + i));
	endtask

	task automatic run_program(input int kind, input string name);
		int seen;
		int idle;
		@(posedge clk);
		reset <= 1'b1;
		@(posedge clk);
		build_program(kind);
		got_addr.delete();
		got_data.delete();
		@(posedge clk);
		@(posedge clk);
		reset <= 1'b0;
		// pc walks the NOPs and LDIs, no memory strobes
		for (int i = 0; i < 8; i++) begin
			@(posedge clk);
			check_addr($sformatf("%s pc", name), 16'(i), pc);
			if (data_wen || data_ren) begin
				errors++;
				$display("%s: data memory strobe active right after reset", name);
			end
		end
		seen = 0;
		idle = 0;
		while (got_addr.size() < exp_addr.size() && idle < STORE_TIMEOUT) begin
			@(posedge clk);
			if (got_addr.size() != seen) begin
				seen = got_addr.size();
				idle = 0;
			end else begin
				idle++;
			end
		end
		if (got_addr.size() < exp_addr.size()) begin
			errors++;
			timed_out = 1'b1;
			$display("%s: no store arrived within %0d cycles, %0d of %0d stores seen",
				name, STORE_TIMEOUT, got_addr.size(), exp_addr.size());
		end else begin
			for (int i = 0; i < exp_addr.size(); i++) begin
				check_addr($sformatf("%s store %0d addr", name, i), exp_addr[i], got_addr[i]);
				check_byte($sformatf("%s store %0d data", name, i), exp_data[i], got_data[i]);
			end
		end
	endtask

	initial begin
		seed = 32'h9db1_166b;
		errors = 0;
		checks = 0;
		timed_out = 1'b0;
		// Load source bytes mix both address halves
		for (int a = 0; a < 65536; a++)
			dmem[16'(a)] = (8'(a) * 8'd29) ^ 8'(a >> 8);
		run_program(0, "ldi_sts");
		if (!timed_out)
			run_program(1, "alu_mix");
		if (!timed_out)
			run_program(2, "carry_chain");
		if (!timed_out)
			run_program(3, "lds_unary");
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* all.f */
+incdir+.
avr_pkg.sv
avr_alu.sv
avr_regfile.sv
avr_decode.sv
avr_execute.sv
avr_cpu.sv
tb_avr_cpu.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     := --binary --timing --timescale 1ns/1ps -j 0
TOP       := tb_avr_cpu
FILELIST  := all.f
BUILD     := obj_dir
SIM       := $(BUILD)/V$(TOP)
LOG       := sim.log
SRCS      := $(shell grep -v '^+' $(FILELIST))
HDRS      := avr_params.svh

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -qx "Test completed successfully" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
